// File: src/rvPkg.sv
`default_nettype none

package rvPkg;

  // ====================
  // field widths
  // ====================
  typedef logic [31:0] instrT;   // raw instruction word
  typedef logic [6:0]  opcodeT;  // instr[6:0]
  typedef logic [4:0]  regIdxT;  // rs1 / rs2 / rd index
  typedef logic [31:0] wordT;    // data and immediates
  typedef logic [2:0]  immTypeT; // immediate layout select
  typedef logic [4:0]  aluOpT;   // execute ALU op

  // ====================
  // opcodes, RV32I base
  // ====================
  localparam opcodeT OPCODE_LOAD   = 7'b0000011;
  localparam opcodeT OPCODE_OP_IMM = 7'b0010011;
  localparam opcodeT OPCODE_AUIPC  = 7'b0010111;
  localparam opcodeT OPCODE_STORE  = 7'b0100011;
  localparam opcodeT OPCODE_RTYPE  = 7'b0110011;
  localparam opcodeT OPCODE_LUI    = 7'b0110111;
  localparam opcodeT OPCODE_BRANCH = 7'b1100011;
  localparam opcodeT OPCODE_JALR   = 7'b1100111;
  localparam opcodeT OPCODE_JAL    = 7'b1101111;

  // ====================
  // immediate types
  // ====================
  localparam immTypeT IMM_NO = 3'd0; // no immediate, imm is zero
  localparam immTypeT IMM_I  = 3'd1;
  localparam immTypeT IMM_S  = 3'd2;
  localparam immTypeT IMM_B  = 3'd3;
  localparam immTypeT IMM_U  = 3'd4;
  localparam immTypeT IMM_J  = 3'd5;

  // ====================
  // ALU operations
  // ====================
  localparam aluOpT ALU_ADD   = 5'd0;
  localparam aluOpT ALU_SUB   = 5'd1;  // also branch compare
  localparam aluOpT ALU_SLL   = 5'd2;
  localparam aluOpT ALU_SLT   = 5'd3;
  localparam aluOpT ALU_SLTU  = 5'd4;
  localparam aluOpT ALU_XOR   = 5'd5;
  localparam aluOpT ALU_SRL   = 5'd6;
  localparam aluOpT ALU_SRA   = 5'd7;
  localparam aluOpT ALU_OR    = 5'd8;
  localparam aluOpT ALU_AND   = 5'd9;
  localparam aluOpT ALU_PASSB = 5'd10; // operand b straight through, for LUI

endpackage

`default_nettype wire

// File: src/pipePkg.sv
`default_nettype none

package pipePkg;

  // ====================
  // flow control sizing
  // ====================
  localparam int QUEUE_DEPTH = 4; // decode queue entries, fetch credit pool
  localparam int EX_CREDITS  = 2; // execute input buffer slots

  // counts 0..QUEUE_DEPTH, so also covers the execute pool
  typedef logic [2:0] creditCntT;

  // indexes one queue entry
  typedef logic [1:0] queuePtrT;

endpackage

`default_nettype wire

// File: src/decoder.sv
`timescale 1ns/1ps
`default_nettype none

module decoder (
  input  wire rvPkg::instrT instr,     // from fetch
  output rvPkg::aluOpT      aluOperation,
  output logic              rd1Sel,    // 1: operand a is PC
  output logic              rd2Sel,    // 1: operand b is imm
  output rvPkg::immTypeT    immType,
  output logic              regWriteEn,
  output logic              instrIllegal
);

  rvPkg::opcodeT opcode;
  logic [2:0]    funct3;
  logic          bit30; // funct7 alt bit, SUB / SRA

  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign bit30  = instr[30];

  // funct3 -> ALU op, alt picks SUB / SRA
  function automatic rvPkg::aluOpT funct3Alu(input logic [2:0] f3, input logic alt);
    rvPkg::aluOpT op;
    case (f3)
      3'b000:  op = alt ? rvPkg::ALU_SUB : rvPkg::ALU_ADD;
      3'b001:  op = rvPkg::ALU_SLL;
      3'b010:  op = rvPkg::ALU_SLT;
      3'b011:  op = rvPkg::ALU_SLTU;
      3'b100:  op = rvPkg::ALU_XOR;
      3'b101:  op = alt ? rvPkg::ALU_SRA : rvPkg::ALU_SRL;
      3'b110:  op = rvPkg::ALU_OR;
      default: op = rvPkg::ALU_AND;
    endcase
    return op;
  endfunction

  // ====================
  // opcode decode
  // ====================
  always_comb begin
    // defaults: legal, no imm, add, rs1 + imm, writes rd
    instrIllegal = 1'b0;
    immType      = rvPkg::IMM_NO;
    aluOperation = rvPkg::ALU_ADD;
    rd1Sel       = 1'b0;
    rd2Sel       = 1'b1;
    regWriteEn   = 1'b1;
    case (opcode)
      rvPkg::OPCODE_LOAD: begin
        immType = rvPkg::IMM_I; // address add
      end
      rvPkg::OPCODE_OP_IMM: begin
        immType      = rvPkg::IMM_I;
        // no SUBI, bit 30 only matters for SRAI
        aluOperation = funct3Alu(funct3, bit30 & (funct3 == 3'b101));
      end
      rvPkg::OPCODE_AUIPC: begin
        immType = rvPkg::IMM_U;
        rd1Sel  = 1'b1; // pc + imm
      end
      rvPkg::OPCODE_STORE: begin
        immType    = rvPkg::IMM_S;
        regWriteEn = 1'b0;
      end
      rvPkg::OPCODE_RTYPE: begin
        immType      = rvPkg::IMM_NO;
        aluOperation = funct3Alu(funct3, bit30);
        rd2Sel       = 1'b0; // rs2
      end
      rvPkg::OPCODE_LUI: begin
        immType      = rvPkg::IMM_U;
        aluOperation = rvPkg::ALU_PASSB;
      end
      rvPkg::OPCODE_BRANCH: begin
        immType      = rvPkg::IMM_B;
        aluOperation = rvPkg::ALU_SUB; // rs1 - rs2 compare
        rd2Sel       = 1'b0;
        regWriteEn   = 1'b0;
      end
      rvPkg::OPCODE_JALR: begin
        immType = rvPkg::IMM_I;
        rd1Sel  = 1'b1;
      end
      rvPkg::OPCODE_JAL: begin
        immType = rvPkg::IMM_J;
        rd1Sel  = 1'b1;
      end
      default: begin
        instrIllegal = 1'b1;
        regWriteEn   = 1'b0; // never commit an unknown op
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/immGen.sv
`timescale 1ns/1ps
`default_nettype none

module immGen (
  input  wire rvPkg::instrT    instr,
  input  wire rvPkg::immTypeT  immType,
  output rvPkg::wordT          imm      // sign-extended from instr[31]
);

  logic sign;

  assign sign = instr[31];

  // ====================
  // layout select
  // ====================
  always_comb begin
    case (immType)
      rvPkg::IMM_I: begin
        imm = {{20{sign}}, instr[31:20]};
      end
      rvPkg::IMM_S: begin
        imm = {{20{sign}}, instr[31:25], instr[11:7]}; // split across rd slot
      end
      rvPkg::IMM_B: begin
        // bit 0 implied zero, halfword offsets
        imm = {{19{sign}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
      end
      rvPkg::IMM_U: begin
        imm = {instr[31:12], 12'b0}; // upper 20, low bits zero
      end
      rvPkg::IMM_J: begin
        imm = {{11{sign}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};
      end
      default: begin
        imm = '0; // IMM_NO and unused codes
      end
    endcase
  end

endmodule

`default_nettype wire

// File: src/regFile.sv
`timescale 1ns/1ps
`default_nettype none

module regFile (
  input  wire                 clk,
  input  wire                 arstN,
  input  wire rvPkg::regIdxT  rs1Idx,
  input  wire rvPkg::regIdxT  rs2Idx,
  output rvPkg::wordT         rs1Data,
  output rvPkg::wordT         rs2Data,
  input  wire                 wbEn,    // writeback port
  input  wire rvPkg::regIdxT  wbIdx,
  input  wire rvPkg::wordT    wbData
);

  // x1..x31 only, x0 has no storage
  rvPkg::wordT regs [1:31];

  // ====================
  // write port
  // ====================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      for (int i = 1; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wbEn && (wbIdx != '0)) begin // drop x0 writes
      regs[wbIdx] <= wbData;
    end
  end

  // ====================
  // read ports
  // ====================
  // combinational, old value on a same-edge write
  assign rs1Data = (rs1Idx == '0) ? '0 : regs[rs1Idx];
  assign rs2Data = (rs2Idx == '0) ? '0 : regs[rs2Idx];

endmodule

`default_nettype wire

// File: src/decodeQueue.sv
`timescale 1ns/1ps
`default_nettype none

module decodeQueue (
  input  wire                 clk,
  input  wire                 arstN,
  input  wire                 push,          // fetch holds a credit for this
  input  wire rvPkg::instrT   pushInstr,
  input  wire rvPkg::aluOpT   pushAluOp,
  input  wire                 pushRd1Sel,
  input  wire                 pushRd2Sel,
  input  wire rvPkg::wordT    pushImm,
  input  wire                 pushRegWriteEn,
  input  wire                 pushIllegal,
  input  wire                 exCredit,      // execute freed one slot
  output logic                pop,           // head leaves this cycle
  output rvPkg::instrT        headInstr,
  output rvPkg::aluOpT        headAluOp,
  output logic                headRd1Sel,
  output logic                headRd2Sel,
  output rvPkg::wordT         headImm,
  output logic                headRegWriteEn,
  output logic                headIllegal
);

  rvPkg::instrT  instrQ  [pipePkg::QUEUE_DEPTH];
  rvPkg::aluOpT  aluOpQ  [pipePkg::QUEUE_DEPTH];
  rvPkg::wordT   immQ    [pipePkg::QUEUE_DEPTH];
  logic [3:0]    flagsQ  [pipePkg::QUEUE_DEPTH]; // rd1Sel, rd2Sel, regWriteEn, illegal

  pipePkg::queuePtrT  wrPtr, rdPtr;
  pipePkg::creditCntT count;  // entries held
  pipePkg::creditCntT exCnt;  // execute credits held

  function automatic pipePkg::queuePtrT nextPtr(input pipePkg::queuePtrT p);
    return (p == pipePkg::queuePtrT'(pipePkg::QUEUE_DEPTH - 1)) ? '0 : p + 2'd1;
  endfunction

  assign pop = (count != '0) && (exCnt != '0);

  // ====================
  // payload storage
  // ====================
  always_ff @(posedge clk) begin
    if (push) begin
      instrQ[wrPtr] <= pushInstr;
      aluOpQ[wrPtr] <= pushAluOp;
      immQ[wrPtr]   <= pushImm;
      flagsQ[wrPtr] <= {pushRd1Sel, pushRd2Sel, pushRegWriteEn, pushIllegal};
    end
  end

  // ====================
  // pointers and credits
  // ====================
  always_ff @(posedge clk or negedge arstN) begin
    if (!arstN) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
      exCnt <= pipePkg::creditCntT'(pipePkg::EX_CREDITS); // full pool
    end else begin
      if (push) wrPtr <= nextPtr(wrPtr);
      if (pop)  rdPtr <= nextPtr(rdPtr);
      case ({push, pop})
        2'b10:   count <= count + 3'd1;
        2'b01:   count <= count - 3'd1;
        default: count <= count; // both or neither
      endcase
      case ({pop, exCredit}) // spend and return can coincide
        2'b10:   exCnt <= exCnt - 3'd1;
        2'b01:   exCnt <= exCnt + 3'd1;
        default: exCnt <= exCnt;
      endcase
    end
  end

  assign headInstr = instrQ[rdPtr];
  assign headAluOp = aluOpQ[rdPtr];
  assign headImm   = immQ[rdPtr];
  assign {headRd1Sel, headRd2Sel, headRegWriteEn, headIllegal} = flagsQ[rdPtr];

endmodule

`default_nettype wire

// File: src/idStage.sv
`timescale 1ns/1ps
`default_nettype none

module idStage (
  input  wire                 clk,
  input  wire                 arstN,
  // fetch side
  input  wire                 instrValid,
  input  wire rvPkg::instrT   instr,
  output logic                fetchCredit,  // one per entry leaving
  // execute side
  output logic                outValid,
  output rvPkg::aluOpT        aluOperation,
  output logic                rd1Sel,
  output logic                rd2Sel,
  output logic                regWriteEn,
  output logic                instrIllegal,
  output rvPkg::wordT         imm,
  output rvPkg::wordT         rs1Data,
  output rvPkg::wordT         rs2Data,
  output rvPkg::regIdxT       rdIdx,
  input  wire                 exCredit,
  // writeback
  input  wire                 wbEn,
  input  wire rvPkg::regIdxT  wbIdx,
  input  wire rvPkg::wordT    wbData
);

  // decode of the incoming word
  rvPkg::aluOpT   decAluOp;
  logic           decRd1Sel, decRd2Sel, decRegWriteEn, decIllegal;
  rvPkg::immTypeT decImmType;
  rvPkg::wordT    decImm;

  rvPkg::instrT   headInstr; // oldest queued word, for register indices
  logic           pop;

  // ====================
  // decode
  // ====================
  decoder uDecoder (
    .instr        (instr),
    .aluOperation (decAluOp),
    .rd1Sel       (decRd1Sel),
    .rd2Sel       (decRd2Sel),
    .immType      (decImmType),
    .regWriteEn   (decRegWriteEn),
    .instrIllegal (decIllegal)
  );

  immGen uImmGen (
    .instr   (instr),
    .immType (decImmType),
    .imm     (decImm)
  );

  // ====================
  // queue and operands
  // ====================
  decodeQueue uQueue (
    .clk            (clk),
    .arstN          (arstN),
    .push           (instrValid),
    .pushInstr      (instr),
    .pushAluOp      (decAluOp),
    .pushRd1Sel     (decRd1Sel),
    .pushRd2Sel     (decRd2Sel),
    .pushImm        (decImm),
    .pushRegWriteEn (decRegWriteEn),
    .pushIllegal    (decIllegal),
    .exCredit       (exCredit),
    .pop            (pop),
    .headInstr      (headInstr),
    .headAluOp      (aluOperation),
    .headRd1Sel     (rd1Sel),
    .headRd2Sel     (rd2Sel),
    .headImm        (imm),
    .headRegWriteEn (regWriteEn),
    .headIllegal    (instrIllegal)
  );

  regFile uRegFile (
    .clk     (clk),
    .arstN   (arstN),
    .rs1Idx  (headInstr[19:15]), // read in the pop cycle
    .rs2Idx  (headInstr[24:20]),
    .rs1Data (rs1Data),
    .rs2Data (rs2Data),
    .wbEn    (wbEn),
    .wbIdx   (wbIdx),
    .wbData  (wbData)
  );

  assign outValid    = pop;
  assign fetchCredit = pop; // queue slot frees as the bundle leaves
  assign rdIdx       = headInstr[11:7];

endmodule

`default_nettype wire

// File: bench/idStageTb_asserts.sv
`timescale 1ns/1ps
`default_nettype none

module idStageAsserts (
  input wire                     clk,
  input wire                     arstN,
  input wire                     instrValid,
  input wire                     outValid,
  input wire                     fetchCredit,
  input wire                     regWriteEn,
  input wire                     instrIllegal,
  input wire pipePkg::creditCntT count,  // queue occupancy
  input wire pipePkg::creditCntT exCnt   // execute credits held
);

  int failCount = 0; // polled by the testbench top

  // ====================
  // credit rules
  // ====================
  // fetch may only send while a queue slot is free
  fetchCreditHeld: assert property (@(posedge clk) disable iff (!arstN)
    instrValid |-> count < pipePkg::QUEUE_DEPTH)
  else begin
    $error("instrValid sent with no fetch credit left");
    failCount++;
  end

  exPoolBounded: assert property (@(posedge clk) disable iff (!arstN)
    exCnt <= pipePkg::EX_CREDITS)
  else begin
    $error("execute credit count above pool size");
    failCount++;
  end

  // ====================
  // reset and decode
  // ====================
  quietInReset: assert property (@(posedge clk)
    !arstN |-> !outValid && !fetchCredit)
  else begin
    $error("output pulse while in reset");
    failCount++;
  end

  quietAfterReset: assert property (@(posedge clk)
    $rose(arstN) |-> !outValid && !fetchCredit)
  else begin
    $error("output pulse right after reset release");
    failCount++;
  end

  illegalNoWrite: assert property (@(posedge clk) disable iff (!arstN)
    outValid && instrIllegal |-> !regWriteEn)
  else begin
    $error("illegal instruction with regWriteEn set");
    failCount++;
  end

endmodule

bind idStage idStageAsserts asserts_i (
  .clk          (clk),
  .arstN        (arstN),
  .instrValid   (instrValid),
  .outValid     (outValid),
  .fetchCredit  (fetchCredit),
  .regWriteEn   (regWriteEn),
  .instrIllegal (instrIllegal),
  .count        (uQueue.count),
  .exCnt        (uQueue.exCnt)
);

`default_nettype wire

// File: bench/idStageTb.sv
`timescale 1ns/1ps
`default_nettype none

module idStageTb;

  localparam int CLK_PERIOD   = 20;
  localparam int NUM_INSTRS   = 600;
  localparam int STALL_CYCLES = 20;
  localparam int WATCHDOG_NS  = NUM_INSTRS * 10 * CLK_PERIOD; // 10 cycles per instr

  logic           clk = 1'b0;
  logic           arstN;
  logic           instrValid;
  rvPkg::instrT   instr;
  logic           exCredit;
  logic           wbEn;
  rvPkg::regIdxT  wbIdx;
  rvPkg::wordT    wbData;

  wire            fetchCredit;
  wire            outValid;
  wire            rd1Sel;
  wire            rd2Sel;
  wire            regWriteEn;
  wire            instrIllegal;
  rvPkg::aluOpT   aluOperation;
  rvPkg::wordT    imm;
  rvPkg::wordT    rs1Data;
  rvPkg::wordT    rs2Data;
  rvPkg::regIdxT  rdIdx;

  // ====================
  // model state
  // ====================
  logic [15:0]    lfsr;
  int             errCount = 0;
  int             fetchCredits;       // fetch side pool
  int             cycle = 0;
  int             sent = 0;
  bit             stalled = 1'b0;
  rvPkg::instrT   refQ [$];           // sent but not yet presented
  int             dueQ [$];           // cycle each execute credit goes back
  rvPkg::wordT    shadow [32];        // mirror of the register file
  rvPkg::aluOpT   aluTable [8] = '{rvPkg::ALU_ADD, rvPkg::ALU_SLL, rvPkg::ALU_SLT,
                                   rvPkg::ALU_SLTU, rvPkg::ALU_XOR, rvPkg::ALU_SRL,
                                   rvPkg::ALU_OR, rvPkg::ALU_AND};

  idStage dut_i (
    .clk          (clk),
    .arstN        (arstN),
    .instrValid   (instrValid),
    .instr        (instr),
    .fetchCredit  (fetchCredit),
    .outValid     (outValid),
    .aluOperation (aluOperation),
    .rd1Sel       (rd1Sel),
    .rd2Sel       (rd2Sel),
    .regWriteEn   (regWriteEn),
    .instrIllegal (instrIllegal),
    .imm          (imm),
    .rs1Data      (rs1Data),
    .rs2Data      (rs2Data),
    .rdIdx        (rdIdx),
    .exCredit     (exCredit),
    .wbEn         (wbEn),
    .wbIdx        (wbIdx),
    .wbData       (wbData)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  // ====================
  // random source
  // ====================
  function automatic logic [15:0] lfsrNext(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16+x^14+x^13+x^11+1
  endfunction

  function automatic logic [31:0] randBits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsrNext(lfsr); // one step per bit
      v    = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic rvPkg::opcodeT legalOpcode(input int k);
    case (k)
      0:       return rvPkg::OPCODE_LOAD;
      1:       return rvPkg::OPCODE_OP_IMM;
      2:       return rvPkg::OPCODE_AUIPC;
      3:       return rvPkg::OPCODE_STORE;
      4:       return rvPkg::OPCODE_RTYPE;
      5:       return rvPkg::OPCODE_LUI;
      6:       return rvPkg::OPCODE_BRANCH;
      7:       return rvPkg::OPCODE_JALR;
      default: return rvPkg::OPCODE_JAL;
    endcase
  endfunction

  function automatic rvPkg::instrT makeInstr();
    rvPkg::instrT w;
    logic [3:0]   sel;
    w   = randBits(32);
    sel = 4'(randBits(4));
    if (sel < 4'd14) begin
      w[6:0] = legalOpcode(int'(sel) % 9); // else mostly unknown opcodes
    end
    if (randBits(2) == 0) w[19:15] = '0; // often an x0 source
    if (randBits(2) == 0) w[24:20] = '0;
    return w;
  endfunction

  // ====================
  // expected decode
  // ====================
  function automatic void expectDecode(input rvPkg::instrT w, output rvPkg::aluOpT alu,
                                       output logic aSel, output logic bSel,
                                       output logic we, output logic ill,
                                       output rvPkg::wordT im);
    logic [2:0] f3;
    f3   = w[14:12];
    alu  = rvPkg::ALU_ADD; // address and link adds
    aSel = 1'b0;
    bSel = 1'b1;
    we   = 1'b1;
    ill  = 1'b0;
    im   = '0;
    case (w[6:0])
      rvPkg::OPCODE_LOAD: begin
        im = 32'($signed(w[31:20]));
      end
      rvPkg::OPCODE_OP_IMM: begin
        im  = 32'($signed(w[31:20]));
        alu = aluTable[f3];
        if (f3 == 3'd5 && w[30]) alu = rvPkg::ALU_SRA; // srai only and no subi
      end
      rvPkg::OPCODE_AUIPC: begin
        im   = {w[31:12], 12'h000};
        aSel = 1'b1;
      end
      rvPkg::OPCODE_STORE: begin
        im = 32'($signed({w[31:25], w[11:7]}));
        we = 1'b0;
      end
      rvPkg::OPCODE_RTYPE: begin
        alu  = aluTable[f3];
        bSel = 1'b0;
        if (w[30] && f3 == 3'd0) alu = rvPkg::ALU_SUB;
        if (w[30] && f3 == 3'd5) alu = rvPkg::ALU_SRA;
      end
      rvPkg::OPCODE_LUI: begin
        im  = {w[31:12], 12'h000};
        alu = rvPkg::ALU_PASSB;
      end
      rvPkg::OPCODE_BRANCH: begin
        im   = 32'($signed({w[31], w[7], w[30:25], w[11:8], 1'b0}));
        alu  = rvPkg::ALU_SUB;
        bSel = 1'b0;
        we   = 1'b0;
      end
      rvPkg::OPCODE_JALR: begin
        im   = 32'($signed(w[31:20]));
        aSel = 1'b1;
      end
      rvPkg::OPCODE_JAL: begin
        im   = 32'($signed({w[31], w[19:12], w[20], w[30:21], 1'b0}));
        aSel = 1'b1;
      end
      default: begin
        ill = 1'b1;
        we  = 1'b0;
      end
    endcase
  endfunction

  // ====================
  // checks
  // ====================
  task automatic compareField(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    assert (got === exp) else begin
      $display("ERR %s got 0x%h expected 0x%h", name, got, exp);
      errCount++;
    end
  endtask

  task automatic checkBundle();
    rvPkg::instrT w;
    rvPkg::aluOpT expAlu;
    logic         expRd1;
    logic         expRd2;
    logic         expWe;
    logic         expIll;
    rvPkg::wordT  expImm;
    int           held;
    held = pipePkg::EX_CREDITS - dueQ.size() - int'(exCredit); // pulse lands at next edge
    assert (held > 0) else begin
      $display("outValid raised while no execute credit was held");
      errCount++;
    end
    assert (refQ.size() != 0) else begin
      $display("bundle presented with no instruction outstanding");
      errCount++;
    end
    if (refQ.size() != 0) begin
      w = refQ.pop_front();
      expectDecode(w, expAlu, expRd1, expRd2, expWe, expIll, expImm);
      compareField("rdIdx", 32'(rdIdx), 32'(w[11:7]));
      compareField("rs1Data", rs1Data, (w[19:15] == 5'd0) ? 32'd0 : shadow[w[19:15]]);
      compareField("rs2Data", rs2Data, (w[24:20] == 5'd0) ? 32'd0 : shadow[w[24:20]]);
      compareField("instrIllegal", 32'(instrIllegal), 32'(expIll));
      compareField("regWriteEn", 32'(regWriteEn), 32'(expWe));
      if (!expIll) begin
        compareField("aluOperation", 32'(aluOperation), 32'(expAlu));
        compareField("rd1Sel", 32'(rd1Sel), 32'(expRd1));
        compareField("rd2Sel", 32'(rd2Sel), 32'(expRd2));
        compareField("imm", imm, expImm);
      end
      dueQ.push_back(cycle + 1 + int'(randBits(2))); // execute holds 0..3 cycles
    end
  endtask

  // drive at +1 ns and check at the falling edge
  task automatic stepCycle(input bit sendOk, input bit returnOk);
    int pick;
    @(posedge clk);
    #1;
    if (wbEn && wbIdx != 5'd0) shadow[wbIdx] = wbData; // committed at this edge
    instrValid = 1'b0;
    if (sendOk && fetchCredits > 0 && randBits(2) != 0) begin
      instr      = makeInstr();
      instrValid = 1'b1;
      fetchCredits--;
      refQ.push_back(instr);
      sent++;
    end
    pick = -1;
    if (returnOk) begin
      foreach (dueQ[k]) begin
        if (pick < 0 && dueQ[k] <= cycle) pick = k;
      end
    end
    exCredit = (pick >= 0);
    if (pick >= 0) dueQ.delete(pick);
    wbEn   = (randBits(1) != 0);
    wbIdx  = rvPkg::regIdxT'(randBits(5)); // x0 included and must be dropped
    wbData = randBits(32);
    @(negedge clk);
    if (outValid) checkBundle();
    if (fetchCredit) fetchCredits++;
    assert (fetchCredits <= pipePkg::QUEUE_DEPTH) else begin
      $display("fetch credits grew beyond the queue depth");
      errCount++;
    end
    cycle++;
  endtask

  // ====================
  // main sequence
  // ====================
  initial begin
    arstN        = 1'b0;
    instrValid   = 1'b0;
    instr        = '0;
    exCredit     = 1'b0;
    wbEn         = 1'b0;
    wbIdx        = '0;
    wbData       = '0;
    lfsr         = 16'd31381;
    fetchCredits = pipePkg::QUEUE_DEPTH;
    foreach (shadow[i]) shadow[i] = '0;
    repeat (2) @(posedge clk);
    #1;
    arstN = 1'b1;
    while (sent < NUM_INSTRS) begin
      if (sent == NUM_INSTRS / 2 && !stalled) begin
        repeat (STALL_CYCLES) stepCycle(1'b1, 1'b0); // execute withholds credits
        assert (fetchCredits == 0 && refQ.size() == pipePkg::QUEUE_DEPTH) else begin
          $display("queue did not fill while execute credits were withheld");
          errCount++;
        end
        stalled = 1'b1;
      end
      stepCycle(1'b1, 1'b1);
    end
    while (refQ.size() != 0 || dueQ.size() != 0) begin
      stepCycle(1'b0, 1'b1); // drain
    end
    repeat (4) stepCycle(1'b0, 1'b1); // idle and nothing may come out
    assert (fetchCredits == pipePkg::QUEUE_DEPTH) else begin
      $display("fetch credits not all returned after the drain");
      errCount++;
    end
    if (errCount == 0 && dut_i.asserts_i.failCount == 0) begin
      $display("Test passed");
      $finish;
    end else begin
      $display("Test failed");
      $fatal(1, "checks failed during the run");
    end
  end

  // stop at the first failed check here or in the bound assertions
  initial begin
    wait (errCount != 0 || dut_i.asserts_i.failCount != 0);
    $display("Test failed");
    $fatal(1, "stopping at the first error");
  end

  initial begin
    #(WATCHDOG_NS);
    $display("Test failed");
    $fatal(1, "watchdog expired before all instructions drained");
  end

endmodule

`default_nettype wire

// File: src.f
src/rvPkg.sv
src/pipePkg.sv
src/decoder.sv
src/immGen.sv
src/regFile.sv
src/decodeQueue.sv
src/idStage.sv
bench/idStageTb_asserts.sv
bench/idStageTb.sv
